// ==== sim.f ====
hw/ex_pkg.sv
hw/ex_alu.sv
hw/ex_mul.sv
hw/ex_hilo.sv
hw/ex_madd_fsm.sv
hw/ex_stage.sv
tb/tb_clk_gen.sv
tb/ex_tb.sv

// ==== Makefile ====
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal
TOP      ?= ex_tb
FILELIST ?= sim.f

OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/ex_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_tb;

    import ex_pkg::*;

    logic    clk;
    logic    rst_n;
    ex_req_t req;
    ex_res_t res;
    logic    busy;
    word_t   hi;
    word_t   lo;
    word_t   m_hi;      // reference copy of hi/lo
    word_t   m_lo;
    word_t   lcg_state;
    int      errors;
    int      checks;
    int      tests;
    int      err_mark;

    tb_clk_gen #(.PERIOD_NS(8)) u_clk (.clk_o(clk));

    ex_stage u_dut (
        .clk     (clk),
        .rst_n_i (rst_n),
        .req_i   (req),
        .res_o   (res),
        .busy_o  (busy),
        .hi_o    (hi),
        .lo_o    (lo)
    );

    // accumulate ops hold busy for a single cycle, then the result pulse follows
    busy_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) busy |=> !busy)
        else begin
            errors = errors + 1;
            $display("CHECK FAILED at %0t: busy_o high for more than one cycle", $time);
        end
    busy_then_result: assert property (@(posedge clk) disable iff (!rst_n) busy |=> res.valid)
        else begin
            errors = errors + 1;
            $display("CHECK FAILED at %0t: no result pulse after busy_o", $time);
        end

    function automatic word_t rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic alusel_e sel_of(input aluop_e op);
        case (op)
            OP_OR, OP_AND, OP_NOR, OP_XOR: return SEL_LOGIC;
            OP_SLL, OP_SRL, OP_SRA:        return SEL_SHIFT;
            OP_MFHI, OP_MFLO:              return SEL_MOVE;
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU, OP_CLZ, OP_CLO: return SEL_ARITH;
            OP_MUL:                        return SEL_MUL;
            default:                       return SEL_NOP;
        endcase
    endfunction

    function automatic dword_t model_prod(input aluop_e op, input word_t a, input word_t b);
        if (op inside {OP_MUL, OP_MULT, OP_MADD, OP_MSUB}) begin
            return dword_t'($signed({{XLEN{a[XLEN-1]}}, a}) * $signed({{XLEN{b[XLEN-1]}}, b}));
        end else begin
            return {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        end
    endfunction

    // signed overflow from a sign-extended 33-bit sum
    function automatic logic model_ov(input aluop_e op, input word_t a, input word_t b);
        logic [XLEN:0] s;
        if (op == OP_ADD) begin
            s = {a[XLEN-1], a} + {b[XLEN-1], b};
        end else if (op == OP_SUB) begin
            s = {a[XLEN-1], a} - {b[XLEN-1], b};
        end else begin
            s = '0;
        end
        return s[XLEN] != s[XLEN-1];
    endfunction

    function automatic word_t count_leading(input word_t v, input logic b);
        int n;
        n = 0;
        while (n < XLEN && v[XLEN-1-n] == b) begin
            n++;
        end
        return word_t'(n);
    endfunction

    function automatic word_t model_word(input aluop_e op, input word_t a, input word_t b);
        dword_t p;
        p = model_prod(op, a, b);
        case (op)
            OP_OR:   return a | b;
            OP_AND:  return a & b;
            OP_NOR:  return ~(a | b);
            OP_XOR:  return a ^ b;
            OP_SLL:  return b << a[4:0];  // rt shifted by low bits of rs
            OP_SRL:  return b >> a[4:0];
            OP_SRA:  return word_t'($signed(b) >>> a[4:0]);
            OP_ADD, OP_ADDU: return a + b;
            OP_SUB, OP_SUBU: return a - b;
            OP_SLT:  return word_t'($signed(a) < $signed(b));
            OP_SLTU: return word_t'(a < b);
            OP_CLZ:  return count_leading(a, 1'b0);
            OP_CLO:  return count_leading(a, 1'b1);
            OP_MUL:  return p[XLEN-1:0];
            OP_MFHI: return m_hi;
            OP_MFLO: return m_lo;
            default: return '0;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // drive one request, wait for its result and compare with the model
    task automatic exec(input aluop_e op, input word_t a, input word_t b, input logic poke);
        int        cycles;
        logic      busy1;
        logic      accum;
        logic      wr;
        reg_addr_t wd;
        word_t     exp_data;
        logic      exp_wreg;
        dword_t    prod;
        accum    = op inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
        wr       = !(accum || (op inside {OP_MULT, OP_MULTU, OP_MTHI, OP_MTLO}));
        wd       = reg_addr_t'(rand_word());
        exp_data = model_word(op, a, b);
        exp_wreg = wr && !model_ov(op, a, b);
        prod     = model_prod(op, a, b);
        req        = '0;
        req.valid  = 1'b1;
        req.aluop  = op;
        req.alusel = sel_of(op);
        req.reg1   = a;
        req.reg2   = b;
        req.wd     = wd;
        req.wreg   = wr;
        cycles = 0;
        busy1  = 1'b0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles == 1) begin
                busy1     = busy;
                req.valid = poke;  // same op again while busy
            end else begin
                req.valid = 1'b0;
            end
        end while (!res.valid && cycles < 20);
        if (!res.valid) begin
            errors++;
            $display("timeout: no result for %s within %0d cycles", op.name(), cycles);
        end else begin
            case (op)
                OP_MULT, OP_MULTU: {m_hi, m_lo} = prod;
                OP_MTHI: m_hi = a;
                OP_MTLO: m_lo = a;
                OP_MADD, OP_MADDU: {m_hi, m_lo} = {m_hi, m_lo} + prod;
                OP_MSUB, OP_MSUBU: {m_hi, m_lo} = {m_hi, m_lo} - prod;
                default: ;
            endcase
            check_value({op.name(), " latency"}, 64'(cycles), accum ? 64'd2 : 64'd1);
            check_value({op.name(), " busy"}, 64'(busy1), 64'(accum));
            check_value({op.name(), " wdata"}, 64'(res.wdata), accum ? 64'd0 : 64'(exp_data));
            check_value({op.name(), " wreg"}, 64'(res.wreg), accum ? 64'd0 : 64'(exp_wreg));
            check_value({op.name(), " wd"}, 64'(res.wd), accum ? 64'd0 : 64'(wd));
            check_value({op.name(), " hi"}, 64'(hi), 64'(m_hi));
            check_value({op.name(), " lo"}, 64'(lo), 64'(m_lo));
        end
    endtask

    task automatic expect_quiet(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            check_value("extra result pulse", 64'(res.valid), 64'd0);
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("test %-12s %0s", name, (errors == err_mark) ? "ok" : "errors");
        err_mark = errors;
    endtask

    initial begin
        aluop_e logic_ops[7];
        aluop_e arith_ops[8];
        aluop_e accum_ops[4];
        logic_ops = '{OP_OR, OP_AND, OP_NOR, OP_XOR, OP_SLL, OP_SRL, OP_SRA};
        arith_ops = '{OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU, OP_CLZ, OP_CLO};
        accum_ops = '{OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
        lcg_state = 32'h1ac7;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        err_mark  = 0;
        m_hi      = '0;
        m_lo      = '0;
        rst_n     = 1'b0;
        req       = '0;

        repeat (5) @(posedge clk);
        #1;
        check_value("valid in reset", 64'(res.valid), 64'd0);
        check_value("busy in reset", 64'(busy), 64'd0);
        check_value("hilo in reset", {hi, lo}, 64'd0);
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value("res after reset", 64'(res), 64'd0);
        check_value("busy after reset", 64'(busy), 64'd0);
        check_value("hilo after reset", {hi, lo}, 64'd0);
        report_test("reset");

        foreach (logic_ops[i]) begin
            repeat (6) exec(logic_ops[i], rand_word(), rand_word(), 1'b0);
        end
        report_test("logic_shift");

        foreach (arith_ops[i]) begin
            repeat (6) exec(arith_ops[i], rand_word(), rand_word(), 1'b0);
        end
        exec(OP_CLZ, 32'h0, 32'h0, 1'b0);
        exec(OP_CLZ, 32'hffff_ffff, 32'h0, 1'b0);
        exec(OP_CLO, 32'h0, 32'h0, 1'b0);
        exec(OP_CLO, 32'hffff_ffff, 32'h0, 1'b0);
        exec(OP_ADD, 32'h7fff_ffff, 32'h1, 1'b0);   // overflow drops wreg
        exec(OP_SUB, 32'h8000_0000, 32'h1, 1'b0);
        exec(OP_ADDU, 32'h7fff_ffff, 32'h1, 1'b0);
        exec(OP_SUBU, 32'h8000_0000, 32'h1, 1'b0);
        report_test("arith");

        repeat (4) exec(OP_MUL, rand_word(), rand_word(), 1'b0);
        repeat (4) exec(OP_MULT, rand_word(), rand_word(), 1'b0);
        repeat (4) exec(OP_MULTU, rand_word(), rand_word(), 1'b0);
        exec(OP_MTHI, rand_word(), rand_word(), 1'b0);
        exec(OP_MFLO, rand_word(), rand_word(), 1'b0);
        exec(OP_MTLO, rand_word(), rand_word(), 1'b0);
        exec(OP_MFHI, rand_word(), rand_word(), 1'b0);
        report_test("mul_move");

        exec(OP_MULT, rand_word(), rand_word(), 1'b0); // nonzero starting hi/lo
        foreach (accum_ops[i]) begin
            repeat (3) begin
                exec(accum_ops[i], rand_word(), rand_word(), 1'b1);
                expect_quiet(3);
            end
        end
        exec(OP_MFHI, 32'h0, 32'h0, 1'b0);
        report_test("accumulate");

        $display("tests %0d, checks %0d, failures %0d", tests, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o; // free running
    end

endmodule

`default_nettype wire

// ==== hw/ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  wire                  clk,
    input  wire                  rst_n_i,
    input  wire ex_pkg::ex_req_t req_i,
    output ex_pkg::ex_res_t      res_o,
    output logic                 busy_o,
    output ex_pkg::word_t        hi_o,
    output ex_pkg::word_t        lo_o
);

    import ex_pkg::*;

    word_t    alu_res;
    logic     alu_ov;
    dword_t   prod;
    dword_t   hilo;     // current hi:lo
    hilo_wr_t hilo_wr;

    ex_alu u_alu (
        .aluop_i  (req_i.aluop),
        .reg1_i   (req_i.reg1),
        .reg2_i   (req_i.reg2),
        .alusel_i (req_i.alusel),
        .hilo_i   (hilo),
        .result_o (alu_res),
        .ov_o     (alu_ov)
    );

    ex_mul u_mul (
        .aluop_i (req_i.aluop),
        .reg1_i  (req_i.reg1),
        .reg2_i  (req_i.reg2),
        .prod_o  (prod)
    );

    // accepts requests and sequences madd/msub
    ex_madd_fsm u_fsm (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .req_i     (req_i),
        .alu_res_i (alu_res),
        .ov_i      (alu_ov),
        .prod_i    (prod),
        .hilo_i    (hilo),
        .res_o     (res_o),
        .hilo_wr_o (hilo_wr),
        .busy_o    (busy_o)
    );

    ex_hilo u_hilo (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .wr_i    (hilo_wr),
        .hilo_o  (hilo)
    );

    assign hi_o = hilo[2*XLEN-1:XLEN];
    assign lo_o = hilo[XLEN-1:0];

endmodule

`default_nettype wire

// ==== hw/ex_madd_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_madd_fsm (
    input  wire                  clk,
    input  wire                  rst_n_i,
    input  wire ex_pkg::ex_req_t req_i,
    input  wire ex_pkg::word_t   alu_res_i,
    input  wire                  ov_i,
    input  wire ex_pkg::dword_t  prod_i,
    input  wire ex_pkg::dword_t  hilo_i,
    output ex_pkg::ex_res_t      res_o,
    output ex_pkg::hilo_wr_t     hilo_wr_o,
    output logic                 busy_o
);

    import ex_pkg::*;

    typedef enum logic {
        IDLE,
        ACCUM  // second cycle of madd/msub
    } state_e;

    state_e state_q;
    state_e state_d;
    dword_t acc_q;     // product to add, already negated for msub
    logic   accept;
    logic   is_accum;
    logic   is_msub;

    assign accept   = (state_q == IDLE) && req_i.valid; // ignored while busy
    assign is_accum = req_i.aluop inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
    assign is_msub  = req_i.aluop inside {OP_MSUB, OP_MSUBU};
    assign busy_o   = (state_q == ACCUM);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept && is_accum) begin
                    state_d = ACCUM;
                end
            end
            ACCUM:   state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    // hi/lo writes land on the same edge as the result register
    always_comb begin
        hilo_wr_o = '0;
        if (state_q == ACCUM) begin
            hilo_wr_o.we   = 1'b1;
            hilo_wr_o.hilo = hilo_i + acc_q;
        end else if (accept) begin
            case (req_i.aluop)
                OP_MULT, OP_MULTU: begin
                    hilo_wr_o.we   = 1'b1;
                    hilo_wr_o.hilo = prod_i;
                end
                OP_MTHI: begin
                    hilo_wr_o.we   = 1'b1;
                    hilo_wr_o.hilo = {req_i.reg1, hilo_i[XLEN-1:0]};       // lo kept
                end
                OP_MTLO: begin
                    hilo_wr_o.we   = 1'b1;
                    hilo_wr_o.hilo = {hilo_i[2*XLEN-1:XLEN], req_i.reg1};  // hi kept
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            res_o   <= '0;
        end else begin
            state_q <= state_d;
            res_o   <= '0; // one-cycle pulse
            if (state_q == ACCUM) begin
                res_o.valid <= 1'b1;  // no gpr write
            end else if (accept && !is_accum) begin
                res_o.valid <= 1'b1;
                res_o.wd    <= req_i.wd;
                res_o.wreg  <= req_i.wreg && !ov_i;
                res_o.wdata <= (req_i.alusel == SEL_MUL) ? prod_i[XLEN-1:0] : alu_res_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && is_accum) begin
            acc_q <= is_msub ? (~prod_i + dword_t'(1)) : prod_i;
        end
    end

endmodule

`default_nettype wire

// ==== hw/ex_hilo.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_hilo (
    input  wire                   clk,
    input  wire                   rst_n_i,
    input  wire ex_pkg::hilo_wr_t wr_i,
    output ex_pkg::dword_t        hilo_o
);

    import ex_pkg::*;

    dword_t hilo_q; // {hi, lo}

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hilo_q <= '0;
        end else if (wr_i.we) begin
            hilo_q <= wr_i.hilo; // both halves at once
        end
    end

    assign hilo_o = hilo_q;

endmodule

`default_nettype wire

// ==== hw/ex_mul.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_mul (
    input  wire ex_pkg::aluop_e aluop_i,
    input  wire ex_pkg::word_t  reg1_i,
    input  wire ex_pkg::word_t  reg2_i,
    output ex_pkg::dword_t      prod_o
);

    import ex_pkg::*;

    logic   is_signed;
    logic   neg;
    word_t  mag1;
    word_t  mag2;
    dword_t raw;

    assign is_signed = aluop_i inside {OP_MUL, OP_MULT, OP_MADD, OP_MSUB};

    // magnitudes of negative operands for signed ops
    assign mag1 = (is_signed && reg1_i[XLEN-1]) ? (~reg1_i + word_t'(1)) : reg1_i;
    assign mag2 = (is_signed && reg2_i[XLEN-1]) ? (~reg2_i + word_t'(1)) : reg2_i;

    assign raw = dword_t'(mag1) * dword_t'(mag2);

    // signs differ, so the product is negative
    assign neg = is_signed && (reg1_i[XLEN-1] ^ reg2_i[XLEN-1]);

    assign prod_o = neg ? (~raw + dword_t'(1)) : raw;

endmodule

`default_nettype wire

// ==== hw/ex_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
    input  wire ex_pkg::aluop_e  aluop_i,
    input  wire ex_pkg::word_t   reg1_i,
    input  wire ex_pkg::word_t   reg2_i,
    input  wire ex_pkg::alusel_e alusel_i,
    input  wire ex_pkg::dword_t  hilo_i,
    output ex_pkg::word_t        result_o,
    output logic                 ov_o
);

    import ex_pkg::*;

    word_t  logic_res;
    word_t  shift_res;
    word_t  move_res;
    word_t  arith_res;
    word_t  reg2_mux;  // reg2 or its two's complement
    word_t  sum;
    shamt_t shamt;
    logic   is_sub;
    logic   add_ov;
    logic   sub_ov;
    logic   lt_signed;
    logic   lt_unsigned;

    // count leading bits equal to bit_val, scanning from the msb
    function automatic word_t lead_count(input word_t val, input logic bit_val);
        word_t cnt;
        logic  done;
        cnt  = '0;
        done = 1'b0;
        for (int i = XLEN - 1; i >= 0; i--) begin
            if (!done && (val[i] == bit_val)) begin
                cnt = cnt + word_t'(1);
            end else begin
                done = 1'b1;
            end
        end
        return cnt;
    endfunction

    assign shamt  = reg1_i[$bits(shamt_t)-1:0]; // low bits of rs
    assign is_sub = (aluop_i == OP_SUB) || (aluop_i == OP_SUBU);

    assign reg2_mux = is_sub ? (~reg2_i + word_t'(1)) : reg2_i;
    assign sum      = reg1_i + reg2_mux;

    // signed overflow on the true operands
    assign add_ov = (reg1_i[XLEN-1] == reg2_i[XLEN-1]) && (sum[XLEN-1] != reg1_i[XLEN-1]);
    assign sub_ov = (reg1_i[XLEN-1] != reg2_i[XLEN-1]) && (sum[XLEN-1] != reg1_i[XLEN-1]);

    assign ov_o = ((aluop_i == OP_ADD) && add_ov) || ((aluop_i == OP_SUB) && sub_ov);

    assign lt_signed   = $signed(reg1_i) < $signed(reg2_i);
    assign lt_unsigned = reg1_i < reg2_i;

    always_comb begin
        case (aluop_i)
            OP_OR:   logic_res = reg1_i | reg2_i;
            OP_AND:  logic_res = reg1_i & reg2_i;
            OP_NOR:  logic_res = ~(reg1_i | reg2_i);
            OP_XOR:  logic_res = reg1_i ^ reg2_i;
            default: logic_res = '0;
        endcase
    end

    // rt is shifted by rs
    always_comb begin
        case (aluop_i)
            OP_SLL:  shift_res = reg2_i << shamt;
            OP_SRL:  shift_res = reg2_i >> shamt;
            OP_SRA:  shift_res = word_t'($signed(reg2_i) >>> shamt);
            default: shift_res = '0;
        endcase
    end

    always_comb begin
        case (aluop_i)
            OP_MFHI: move_res = hilo_i[2*XLEN-1:XLEN];
            OP_MFLO: move_res = hilo_i[XLEN-1:0];
            default: move_res = '0;
        endcase
    end

    always_comb begin
        case (aluop_i)
            OP_SLT:  arith_res = word_t'(lt_signed);
            OP_SLTU: arith_res = word_t'(lt_unsigned);
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: begin
                arith_res = sum;
            end
            OP_CLZ:  arith_res = lead_count(reg1_i, 1'b0);
            OP_CLO:  arith_res = lead_count(reg1_i, 1'b1);
            default: arith_res = '0;
        endcase
    end

    // mul group is filled in from the multiplier downstream
    always_comb begin
        case (alusel_i)
            SEL_LOGIC: result_o = logic_res;
            SEL_SHIFT: result_o = shift_res;
            SEL_MOVE:  result_o = move_res;
            SEL_ARITH: result_o = arith_res;
            default:   result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/ex_pkg.sv ====
`default_nettype none

package ex_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0]         word_t;     // one gpr word
    typedef logic [2*XLEN-1:0]       dword_t;    // hi:lo or full product
    typedef logic [$clog2(XLEN)-1:0] reg_addr_t; // 32 gprs
    typedef logic [$clog2(XLEN)-1:0] shamt_t;

    // op encodings follow the decode stage
    typedef enum logic [7:0] {
        OP_NOP   = 8'b0000_0000,
        OP_AND   = 8'b0010_0100,
        OP_OR    = 8'b0010_0101,
        OP_XOR   = 8'b0010_0110,
        OP_NOR   = 8'b0010_0111,
        OP_SLL   = 8'b0111_1100,
        OP_SRL   = 8'b0000_0010,
        OP_SRA   = 8'b0000_0011,
        OP_MFHI  = 8'b0001_0000,
        OP_MTHI  = 8'b0001_0001,
        OP_MFLO  = 8'b0001_0010,
        OP_MTLO  = 8'b0001_0011,
        OP_SLT   = 8'b0010_1010,
        OP_SLTU  = 8'b0010_1011,
        OP_ADD   = 8'b0010_0000,
        OP_ADDU  = 8'b0010_0001,
        OP_SUB   = 8'b0010_0010,
        OP_SUBU  = 8'b0010_0011,
        OP_MULT  = 8'b0001_1000,
        OP_MULTU = 8'b0001_1001,
        OP_MUL   = 8'b1010_1001,
        OP_CLZ   = 8'b1011_0000,
        OP_CLO   = 8'b1011_0001,
        OP_MADD  = 8'b1010_0110,
        OP_MADDU = 8'b1010_1000,
        OP_MSUB  = 8'b1010_1010,
        OP_MSUBU = 8'b1010_1011
    } aluop_e;

    // result group, picks which unit feeds wdata
    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_MOVE  = 3'b011,
        SEL_ARITH = 3'b100,
        SEL_MUL   = 3'b101
    } alusel_e;

    typedef struct packed {
        logic      valid;
        aluop_e    aluop;
        alusel_e   alusel;
        word_t     reg1;
        word_t     reg2;
        reg_addr_t wd;    // destination gpr
        logic      wreg;  // gpr write enable
    } ex_req_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t wd;
        logic      wreg;
        word_t     wdata;
    } ex_res_t;

    typedef struct packed {
        logic   we;
        dword_t hilo;
    } hilo_wr_t;

endpackage

`default_nettype wire
